// ==== flist.f ====
+incdir+include
logic/riscv_isa_pkg.sv
logic/riscv_ctrl_pkg.sv
logic/riscv_regfile.sv
logic/riscv_dstage.sv
logic/riscv_estage.sv
logic/riscv_wbstage.sv
logic/riscv_core.sv
verification/riscv_clk_gen.sv
verification/riscv_core_chk.sv
verification/riscv_monitor.sv
verification/riscv_tb.sv

// ==== include/riscv_config.svh ====
`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH

// datapath, pc and register width
`define RISCV_XLEN 32

// architectural integer registers, x0 included
`define RISCV_NREGS 32

// first fetch address out of reset
`define RISCV_RESET_PC 32'h0000_0000

`endif

// ==== logic/riscv_core.sv ====
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_core (
  input  logic                   i_riscv_core_clk,
  input  logic                   i_arst_n,
  input  logic [31:0]            i_inst,
  output logic [`RISCV_XLEN-1:0] o_pc,
  output logic                   o_wb_en,
  output logic [4:0]             o_wb_rd,
  output logic [`RISCV_XLEN-1:0] o_wb_data
);

  // decode to regfile
  logic [4:0]               rs1_addr_d, rs2_addr_d;
  logic [`RISCV_XLEN-1:0]   rs1_data_d, rs2_data_d;
  // execute back to fetch
  logic                     redirect;
  logic [`RISCV_XLEN-1:0]   target;
  // decode/execute bundle
  logic                     valid_e, asel_e, bsel_e, jump_e, regw_e;
  logic [`RISCV_XLEN-1:0]   pc_e, rs1_data_e, rs2_data_e, imm_e;
  logic [4:0]               rs1_addr_e, rs2_addr_e, rd_e;
  riscv_isa_pkg::alu_op_e   alu_op_e;
  riscv_ctrl_pkg::res_src_e res_src_e;
  riscv_ctrl_pkg::br_cond_e br_cond_e;
  // result stage
  logic                     valid_r, regw_r;
  logic [4:0]               rd_r;
  riscv_ctrl_pkg::res_src_e res_src_r;
  logic [`RISCV_XLEN-1:0]   alu_r, pcplus4_r, imm_r;

  riscv_dstage u_riscv_dstage (
    .i_riscv_dstage_clk (i_riscv_core_clk),
    .i_arst_n           (i_arst_n),
    .i_inst             (i_inst),
    .i_redirect         (redirect),
    .i_target           (target),
    .o_pc               (o_pc),
    .o_rs1_addr         (rs1_addr_d),
    .o_rs2_addr         (rs2_addr_d),
    .i_rs1_data         (rs1_data_d),
    .i_rs2_data         (rs2_data_d),
    .o_valid_e          (valid_e),
    .o_pc_e             (pc_e),
    .o_rs1_addr_e       (rs1_addr_e),
    .o_rs2_addr_e       (rs2_addr_e),
    .o_rs1_data_e       (rs1_data_e),
    .o_rs2_data_e       (rs2_data_e),
    .o_rd_e             (rd_e),
    .o_imm_e            (imm_e),
    .o_alu_op_e         (alu_op_e),
    .o_asel_e           (asel_e),
    .o_bsel_e           (bsel_e),
    .o_res_src_e        (res_src_e),
    .o_br_cond_e        (br_cond_e),
    .o_jump_e           (jump_e),
    .o_regw_e           (regw_e)
  );

  riscv_estage u_riscv_estage (
    .i_riscv_estage_clk (i_riscv_core_clk),
    .i_arst_n           (i_arst_n),
    .i_valid            (valid_e),
    .i_pc               (pc_e),
    .i_rs1_addr         (rs1_addr_e),
    .i_rs2_addr         (rs2_addr_e),
    .i_rs1_data         (rs1_data_e),
    .i_rs2_data         (rs2_data_e),
    .i_rd               (rd_e),
    .i_imm              (imm_e),
    .i_alu_op           (alu_op_e),
    .i_asel             (asel_e),
    .i_bsel             (bsel_e),
    .i_res_src          (res_src_e),
    .i_br_cond          (br_cond_e),
    .i_jump             (jump_e),
    .i_regw             (regw_e),
    .i_wb_we            (o_wb_en),
    .i_wb_rd            (o_wb_rd),
    .i_wb_data          (o_wb_data),
    .o_redirect         (redirect),
    .o_target           (target),
    .o_valid_r          (valid_r),
    .o_regw_r           (regw_r),
    .o_rd_r             (rd_r),
    .o_res_src_r        (res_src_r),
    .o_alu_r            (alu_r),
    .o_pcplus4_r        (pcplus4_r),
    .o_imm_r            (imm_r)
  );

  riscv_wbstage u_riscv_wbstage (
    .i_valid            (valid_r),
    .i_regw             (regw_r),
    .i_rd               (rd_r),
    .i_res_src          (res_src_r),
    .i_alu              (alu_r),
    .i_pcplus4          (pcplus4_r),
    .i_imm              (imm_r),
    .o_we               (o_wb_en),
    .o_rd               (o_wb_rd),
    .o_data             (o_wb_data)
  );

  riscv_regfile u_riscv_regfile (
    .i_riscv_regfile_clk (i_riscv_core_clk),
    .i_arst_n            (i_arst_n),
    .i_rs1_addr          (rs1_addr_d),
    .i_rs2_addr          (rs2_addr_d),
    .o_rs1_data          (rs1_data_d),
    .o_rs2_data          (rs2_data_d),
    .i_we                (o_wb_en),
    .i_rd_addr           (o_wb_rd),
    .i_rd_data           (o_wb_data)
  );

endmodule

// ==== logic/riscv_ctrl_pkg.sv ====
package riscv_ctrl_pkg;

  // write-back value source
  typedef enum logic [1:0] {
    RES_ALU = 2'd0,
    RES_PC4 = 2'd1,  // link value of jal
    RES_IMM = 2'd2   // lui
  } res_src_e;

  // operand source in execute
  typedef enum logic [1:0] {
    FWD_REG = 2'd0,  // value read in decode
    FWD_WB  = 2'd1   // value being written by the result stage
  } fwd_sel_e;

  // conditional branch kind
  typedef enum logic [1:0] {
    BR_NONE = 2'd0,
    BR_EQ   = 2'd1,
    BR_NE   = 2'd2
  } br_cond_e;

endpackage

// ==== logic/riscv_dstage.sv ====
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_dstage (
  input  logic                          i_riscv_dstage_clk,
  input  logic                          i_arst_n,
  input  logic [31:0]                   i_inst,
  input  logic                          i_redirect,
  input  logic [`RISCV_XLEN-1:0]        i_target,
  output logic [`RISCV_XLEN-1:0]        o_pc,
  output logic [4:0]                    o_rs1_addr,
  output logic [4:0]                    o_rs2_addr,
  input  logic [`RISCV_XLEN-1:0]        i_rs1_data,
  input  logic [`RISCV_XLEN-1:0]        i_rs2_data,
  output logic                          o_valid_e,
  output logic [`RISCV_XLEN-1:0]        o_pc_e,
  output logic [4:0]                    o_rs1_addr_e,
  output logic [4:0]                    o_rs2_addr_e,
  output logic [`RISCV_XLEN-1:0]        o_rs1_data_e,
  output logic [`RISCV_XLEN-1:0]        o_rs2_data_e,
  output logic [4:0]                    o_rd_e,
  output logic [`RISCV_XLEN-1:0]        o_imm_e,
  output riscv_isa_pkg::alu_op_e        o_alu_op_e,
  output logic                          o_asel_e,
  output logic                          o_bsel_e,
  output riscv_ctrl_pkg::res_src_e      o_res_src_e,
  output riscv_ctrl_pkg::br_cond_e      o_br_cond_e,
  output logic                          o_jump_e,
  output logic                          o_regw_e
);

  localparam logic [`RISCV_XLEN-1:0] PC_STEP = 4;

  logic [`RISCV_XLEN-1:0]   pc_f;
  logic [`RISCV_XLEN-1:0]   pc_d;
  logic [31:0]              inst_d;
  logic                     valid_d;
  logic [6:0]               funct7;
  logic [`RISCV_XLEN-1:0]   imm_i, imm_u, imm_b, imm_j;
  riscv_isa_pkg::opcode_e   opcode;
  riscv_isa_pkg::funct3_e   funct3;
  logic                     legal;
  logic                     regw, jump, asel, bsel;
  riscv_isa_pkg::alu_op_e   alu_op;
  riscv_ctrl_pkg::res_src_e res_src;
  riscv_ctrl_pkg::br_cond_e br_cond;
  logic [`RISCV_XLEN-1:0]   imm;

  // shared by OP and OP_IMM, alt picks sub or sra
  function automatic riscv_isa_pkg::alu_op_e alu_decode(input riscv_isa_pkg::funct3_e f3,
                                                        input logic alt);
    riscv_isa_pkg::alu_op_e op;
    case (f3)
      riscv_isa_pkg::F3_ADD_SUB: op = alt ? riscv_isa_pkg::ALU_SUB : riscv_isa_pkg::ALU_ADD;
      riscv_isa_pkg::F3_SLL:     op = riscv_isa_pkg::ALU_SLL;
      riscv_isa_pkg::F3_SLT:     op = riscv_isa_pkg::ALU_SLT;
      riscv_isa_pkg::F3_SLTU:    op = riscv_isa_pkg::ALU_SLTU;
      riscv_isa_pkg::F3_XOR:     op = riscv_isa_pkg::ALU_XOR;
      riscv_isa_pkg::F3_SRL_SRA: op = alt ? riscv_isa_pkg::ALU_SRA : riscv_isa_pkg::ALU_SRL;
      riscv_isa_pkg::F3_OR:      op = riscv_isa_pkg::ALU_OR;
      default:                   op = riscv_isa_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign o_pc       = pc_f;
  assign o_rs1_addr = inst_d[19:15];
  assign o_rs2_addr = inst_d[24:20];
  assign funct7     = inst_d[31:25];

  // immediate formats
  assign imm_i = {{(`RISCV_XLEN-12){inst_d[31]}}, inst_d[31:20]};
  assign imm_u = {inst_d[31:12], 12'b0};
  assign imm_b = {{(`RISCV_XLEN-13){inst_d[31]}}, inst_d[31], inst_d[7], inst_d[30:25],
                  inst_d[11:8], 1'b0};
  assign imm_j = {{(`RISCV_XLEN-21){inst_d[31]}}, inst_d[31], inst_d[19:12], inst_d[20],
                  inst_d[30:21], 1'b0};

  always_comb begin
    opcode  = riscv_isa_pkg::opcode_e'(inst_d[6:0]);
    funct3  = riscv_isa_pkg::funct3_e'(inst_d[14:12]);
    legal   = 1'b1;
    regw    = 1'b0;
    jump    = 1'b0;
    asel    = 1'b0;  // rs1
    bsel    = 1'b0;  // rs2
    alu_op  = riscv_isa_pkg::ALU_ADD;
    res_src = riscv_ctrl_pkg::RES_ALU;
    br_cond = riscv_ctrl_pkg::BR_NONE;
    imm     = imm_i;
    case (opcode)
      riscv_isa_pkg::OPC_OP: begin
        regw   = 1'b1;
        alu_op = alu_decode(funct3, inst_d[30]);
        legal  = (funct7 == 7'b0000000) ||
                 ((funct7 == 7'b0100000) && ((funct3 == riscv_isa_pkg::F3_ADD_SUB) ||
                                             (funct3 == riscv_isa_pkg::F3_SRL_SRA)));
      end
      riscv_isa_pkg::OPC_OP_IMM: begin
        regw   = 1'b1;
        bsel   = 1'b1;
        alu_op = alu_decode(funct3, inst_d[30] & (funct3 == riscv_isa_pkg::F3_SRL_SRA));
        if (funct3 == riscv_isa_pkg::F3_SLL) begin
          legal = (funct7 == 7'b0000000);
        end else if (funct3 == riscv_isa_pkg::F3_SRL_SRA) begin
          legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end
      end
      riscv_isa_pkg::OPC_LUI: begin
        regw    = 1'b1;
        bsel    = 1'b1;
        imm     = imm_u;
        alu_op  = riscv_isa_pkg::ALU_PASS_B;
        res_src = riscv_ctrl_pkg::RES_IMM;
      end
      riscv_isa_pkg::OPC_AUIPC: begin
        regw = 1'b1;
        asel = 1'b1;  // own pc
        bsel = 1'b1;
        imm  = imm_u;
      end
      riscv_isa_pkg::OPC_JAL: begin
        regw    = 1'b1;
        jump    = 1'b1;
        imm     = imm_j;
        res_src = riscv_ctrl_pkg::RES_PC4;  // link
      end
      riscv_isa_pkg::OPC_BRANCH: begin
        imm = imm_b;
        if (inst_d[14:12] == riscv_isa_pkg::F3_BEQ) begin
          br_cond = riscv_ctrl_pkg::BR_EQ;
        end else if (inst_d[14:12] == riscv_isa_pkg::F3_BNE) begin
          br_cond = riscv_ctrl_pkg::BR_NE;
        end else begin
          legal = 1'b0;
        end
      end
      default: legal = 1'b0;
    endcase
    if (!legal) begin
      regw = 1'b0;  // unsupported word retires as a bubble
    end
  end

  // pc and valid flags, a redirect kills both younger slots
  always_ff @(posedge i_riscv_dstage_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc_f      <= `RISCV_RESET_PC;
      valid_d   <= 1'b0;
      o_valid_e <= 1'b0;
    end else begin
      pc_f      <= i_redirect ? i_target : pc_f + PC_STEP;
      valid_d   <= ~i_redirect;
      o_valid_e <= valid_d & legal & ~i_redirect;
    end
  end

  always_ff @(posedge i_riscv_dstage_clk) begin
    inst_d       <= i_inst;
    pc_d         <= pc_f;
    o_pc_e       <= pc_d;
    o_rs1_addr_e <= o_rs1_addr;
    o_rs2_addr_e <= o_rs2_addr;
    o_rs1_data_e <= i_rs1_data;
    o_rs2_data_e <= i_rs2_data;
    o_rd_e       <= inst_d[11:7];
    o_imm_e      <= imm;
    o_alu_op_e   <= alu_op;
    o_asel_e     <= asel;
    o_bsel_e     <= bsel;
    o_res_src_e  <= res_src;
    o_br_cond_e  <= br_cond;
    o_jump_e     <= jump;
    o_regw_e     <= regw;
  end

endmodule

// ==== logic/riscv_estage.sv ====
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_estage (
  input  logic                     i_riscv_estage_clk,
  input  logic                     i_arst_n,
  input  logic                     i_valid,
  input  logic [`RISCV_XLEN-1:0]   i_pc,
  input  logic [4:0]               i_rs1_addr,
  input  logic [4:0]               i_rs2_addr,
  input  logic [`RISCV_XLEN-1:0]   i_rs1_data,
  input  logic [`RISCV_XLEN-1:0]   i_rs2_data,
  input  logic [4:0]               i_rd,
  input  logic [`RISCV_XLEN-1:0]   i_imm,
  input  riscv_isa_pkg::alu_op_e   i_alu_op,
  input  logic                     i_asel,
  input  logic                     i_bsel,
  input  riscv_ctrl_pkg::res_src_e i_res_src,
  input  riscv_ctrl_pkg::br_cond_e i_br_cond,
  input  logic                     i_jump,
  input  logic                     i_regw,
  input  logic                     i_wb_we,
  input  logic [4:0]               i_wb_rd,
  input  logic [`RISCV_XLEN-1:0]   i_wb_data,
  output logic                     o_redirect,
  output logic [`RISCV_XLEN-1:0]   o_target,
  output logic                     o_valid_r,
  output logic                     o_regw_r,
  output logic [4:0]               o_rd_r,
  output riscv_ctrl_pkg::res_src_e o_res_src_r,
  output logic [`RISCV_XLEN-1:0]   o_alu_r,
  output logic [`RISCV_XLEN-1:0]   o_pcplus4_r,
  output logic [`RISCV_XLEN-1:0]   o_imm_r
);

  localparam int SHW = $clog2(`RISCV_XLEN);
  localparam logic [`RISCV_XLEN-1:0] PC_STEP = 4;

  riscv_ctrl_pkg::fwd_sel_e fwd_a, fwd_b;
  logic [`RISCV_XLEN-1:0]   rs1_val, rs2_val;
  logic [`RISCV_XLEN-1:0]   op_a, op_b;
  logic [`RISCV_XLEN-1:0]   alu;
  logic [SHW-1:0]           shamt;
  logic                     eq;

  // only the result stage can be ahead of execute
  assign fwd_a = (i_wb_we && (i_wb_rd == i_rs1_addr) && (i_rs1_addr != 5'd0)) ?
                 riscv_ctrl_pkg::FWD_WB : riscv_ctrl_pkg::FWD_REG;
  assign fwd_b = (i_wb_we && (i_wb_rd == i_rs2_addr) && (i_rs2_addr != 5'd0)) ?
                 riscv_ctrl_pkg::FWD_WB : riscv_ctrl_pkg::FWD_REG;

  assign rs1_val = (fwd_a == riscv_ctrl_pkg::FWD_WB) ? i_wb_data : i_rs1_data;
  assign rs2_val = (fwd_b == riscv_ctrl_pkg::FWD_WB) ? i_wb_data : i_rs2_data;

  assign op_a  = i_asel ? i_pc : rs1_val;   // auipc uses its own pc
  assign op_b  = i_bsel ? i_imm : rs2_val;
  assign shamt = op_b[SHW-1:0];

  always_comb begin
    case (i_alu_op)
      riscv_isa_pkg::ALU_ADD:  alu = op_a + op_b;
      riscv_isa_pkg::ALU_SUB:  alu = op_a - op_b;
      riscv_isa_pkg::ALU_AND:  alu = op_a & op_b;
      riscv_isa_pkg::ALU_OR:   alu = op_a | op_b;
      riscv_isa_pkg::ALU_XOR:  alu = op_a ^ op_b;
      riscv_isa_pkg::ALU_SLT:  alu = {{(`RISCV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      riscv_isa_pkg::ALU_SLTU: alu = {{(`RISCV_XLEN-1){1'b0}}, op_a < op_b};
      riscv_isa_pkg::ALU_SLL:  alu = op_a << shamt;
      riscv_isa_pkg::ALU_SRL:  alu = op_a >> shamt;
      riscv_isa_pkg::ALU_SRA:  alu = $signed(op_a) >>> shamt;
      default:                 alu = op_b;  // pass_b
    endcase
  end

  // branch compare always on the register operands
  assign eq = (rs1_val == rs2_val);

  assign o_redirect = i_valid & (i_jump |
                      ((i_br_cond == riscv_ctrl_pkg::BR_EQ) & eq) |
                      ((i_br_cond == riscv_ctrl_pkg::BR_NE) & ~eq));
  assign o_target   = i_pc + i_imm;  // pc-relative for jal and branches

  always_ff @(posedge i_riscv_estage_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid_r <= 1'b0;
    end else begin
      o_valid_r <= i_valid;
    end
  end

  always_ff @(posedge i_riscv_estage_clk) begin
    o_regw_r    <= i_regw;
    o_rd_r      <= i_rd;
    o_res_src_r <= i_res_src;
    o_alu_r     <= alu;
    o_pcplus4_r <= i_pc + PC_STEP;
    o_imm_r     <= i_imm;
  end

endmodule

// ==== logic/riscv_isa_pkg.sv ====
package riscv_isa_pkg;

  // major opcodes kept in this subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // funct3 of OP and OP_IMM
  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'b000,
    F3_SLL     = 3'b001,
    F3_SLT     = 3'b010,
    F3_SLTU    = 3'b011,
    F3_XOR     = 3'b100,
    F3_SRL_SRA = 3'b101,
    F3_OR      = 3'b110,
    F3_AND     = 3'b111
  } funct3_e;

  // branch funct3, same codes as add/sll so kept out of the enum
  parameter logic [2:0] F3_BEQ = 3'b000;
  parameter logic [2:0] F3_BNE = 3'b001;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B  // operand b straight through
  } alu_op_e;

endpackage

// ==== logic/riscv_regfile.sv ====
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_regfile (
  input  logic                   i_riscv_regfile_clk,
  input  logic                   i_arst_n,
  input  logic [4:0]             i_rs1_addr,
  input  logic [4:0]             i_rs2_addr,
  output logic [`RISCV_XLEN-1:0] o_rs1_data,
  output logic [`RISCV_XLEN-1:0] o_rs2_data,
  input  logic                   i_we,
  input  logic [4:0]             i_rd_addr,
  input  logic [`RISCV_XLEN-1:0] i_rd_data
);

  logic [`RISCV_XLEN-1:0] regs [`RISCV_NREGS];

  always_ff @(posedge i_riscv_regfile_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < `RISCV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_rd_addr != 5'd0)) begin  // x0 never written
      regs[i_rd_addr] <= i_rd_data;
    end
  end

  // write-through so decode sees the value retiring this cycle
  assign o_rs1_data = (i_rs1_addr == 5'd0) ? '0 :
                      (i_we && (i_rd_addr == i_rs1_addr)) ? i_rd_data : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == 5'd0) ? '0 :
                      (i_we && (i_rd_addr == i_rs2_addr)) ? i_rd_data : regs[i_rs2_addr];

endmodule

// ==== logic/riscv_wbstage.sv ====
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_wbstage (
  input  logic                     i_valid,
  input  logic                     i_regw,
  input  logic [4:0]               i_rd,
  input  riscv_ctrl_pkg::res_src_e i_res_src,
  input  logic [`RISCV_XLEN-1:0]   i_alu,
  input  logic [`RISCV_XLEN-1:0]   i_pcplus4,
  input  logic [`RISCV_XLEN-1:0]   i_imm,
  output logic                     o_we,
  output logic [4:0]               o_rd,
  output logic [`RISCV_XLEN-1:0]   o_data
);

  // x0 targets never reach the write port or the forward path
  assign o_we = i_valid & i_regw & (i_rd != 5'd0);
  assign o_rd = i_rd;

  always_comb begin
    case (i_res_src)
      riscv_ctrl_pkg::RES_PC4: o_data = i_pcplus4;  // jal link
      riscv_ctrl_pkg::RES_IMM: o_data = i_imm;      // lui
      default:                 o_data = i_alu;
    endcase
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# builds the riscv_tb simulation with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -f flist.f --top-module riscv_tb \
  -Mdir "$BUILD_DIR" -o riscv_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

# keep running after an assertion error so the testbench can summarize
"./$BUILD_DIR/riscv_tb_sim" +verilator+error+limit+100 > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q -F '*** FAILED ***' "$LOG_FILE"; then
  exit 1
fi
exit 0

// ==== verification/riscv_clk_gen.sv ====
`timescale 1ns/1ps

module riscv_clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 8
) (
  output logic o_clk,
  output logic o_arst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // release on a falling edge, away from the capture edge
  initial begin
    o_arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_arst_n = 1'b1;
  end

endmodule

// ==== verification/riscv_core_chk.sv ====
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_core_chk (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  input  logic                   i_wb_en,
  input  logic [4:0]             i_wb_rd,
  input  logic [`RISCV_XLEN-1:0] i_pc
);

  int fail_cnt = 0;  // read by the testbench at the end of the run

  // x0 targets are filtered before the write-back port
  a_wb_rd_nonzero: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_wb_en |-> (i_wb_rd != 5'd0))
    else begin
      $error("write-back enable raised with rd x0");
      fail_cnt = fail_cnt + 1;
    end

  a_wb_quiet_in_reset: assert property (@(posedge i_clk) !i_arst_n |-> !i_wb_en)
    else begin
      $error("write-back enable high while reset is asserted");
      fail_cnt = fail_cnt + 1;
    end

  // fetch address stays on a word boundary
  a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_pc[1:0] == 2'b00)
    else begin
      $error("fetch address %08h is not word aligned", i_pc);
      fail_cnt = fail_cnt + 1;
    end

endmodule

// ==== verification/riscv_monitor.sv ====
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_monitor (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  input  logic                   i_wb_en,
  input  logic [4:0]             i_wb_rd,
  input  logic [`RISCV_XLEN-1:0] i_wb_data,
  output int                     o_pass_cnt,
  output int                     o_fail_cnt,
  output logic                   o_all_seen
);

  string                  exp_name [$];
  logic [4:0]             exp_rd [$];
  logic [`RISCV_XLEN-1:0] exp_data [$];
  int                     seen     = 0;
  int                     pass_cnt = 0;
  int                     fail_cnt = 0;
  logic                   all_seen = 1'b0;

  assign o_pass_cnt = pass_cnt;
  assign o_fail_cnt = fail_cnt;
  assign o_all_seen = all_seen;

  // one expected write, appended in retire order
  task automatic add_expect(input string name, input logic [4:0] rd,
                            input logic [`RISCV_XLEN-1:0] data);
    exp_name.push_back(name);
    exp_rd.push_back(rd);
    exp_data.push_back(data);
  endtask

  task automatic check_write();
    if (seen >= exp_rd.size()) begin
      fail_cnt = fail_cnt + 1;
      $display("unexpected write of %08h to x%0d after all %0d expected writes",
               i_wb_data, i_wb_rd, exp_rd.size());
    end else begin
      if ((i_wb_rd !== exp_rd[seen]) || (i_wb_data !== exp_data[seen])) begin
        fail_cnt = fail_cnt + 1;
        $display("[FAIL] %s expected x%0d=%08h actual x%0d=%08h", exp_name[seen],
                 exp_rd[seen], exp_data[seen], i_wb_rd, i_wb_data);
      end else begin
        pass_cnt = pass_cnt + 1;
        $display("[PASS] %s x%0d=%08h", exp_name[seen], i_wb_rd, i_wb_data);
      end
      seen     = seen + 1;
      all_seen = (seen == exp_rd.size());
    end
  endtask

  // mid-cycle sample, write-back outputs settled since the rising edge
  always @(negedge i_clk) begin
    if (i_arst_n && i_wb_en) begin
      check_write();
    end
  end

endmodule

// ==== verification/riscv_tb.sv ====
`timescale 1ns/1ps
`include "riscv_config.svh"

module riscv_tb;

  localparam int PROG_LEN     = 32;
  localparam int EXP_LEN      = 20;
  localparam int IMEM_WORDS   = 64;
  localparam int RESET_CYCLES = 8;
  localparam int DRAIN_CYCLES = 8;  // room for a stray write after the last one
  localparam int CYCLE_LIMIT  = RESET_CYCLES + 4 * PROG_LEN + 40;

  logic                   clk;
  logic                   arst_n;
  logic [31:0]            inst = 32'h0000_0013;  // nop until the first falling edge
  logic [`RISCV_XLEN-1:0] pc;
  logic                   wb_en;
  logic [4:0]             wb_rd;
  logic [`RISCV_XLEN-1:0] wb_data;
  int                     pass_cnt;
  int                     fail_cnt;
  logic                   all_seen;
  int                     cycles;
  logic                   timed_out;
  int                     chk_fails;
  logic [31:0]            imem [IMEM_WORDS];
  logic [31:0]            prog [PROG_LEN];

  // register writes in retire order
  // squashed slots would write x20/x21
  logic [4:0] exp_rd [EXP_LEN] = '{
    5'd1,  5'd2,  5'd3,  5'd4,  5'd5,  5'd6,  5'd7,  5'd8,  5'd9,  5'd10,
    5'd11, 5'd12, 5'd13, 5'd14, 5'd15, 5'd16, 5'd17, 5'd18, 5'd19, 5'd22
  };
  logic [31:0] exp_data [EXP_LEN] = '{
    32'h8000_0000, 32'hffff_fffd, 32'h0000_0004, 32'h0000_000d,
    32'h0000_0001, 32'h0000_0001, 32'hf800_0000, 32'hf800_0004,
    32'h0000_0007, 32'hf800_0000, 32'h0800_0000, 32'hffff_ffd0,
    32'h0000_0001, 32'h0000_0000, 32'hffff_fffa, 32'hffff_fffe,
    32'h0000_0006, 32'h0000_1044, 32'h0000_0004, 32'h0000_0074  // auipc at pc 0x44
  };
  string exp_name [EXP_LEN] = '{
    "lui_x1", "addi_neg_x2", "addi_x3", "xori_neg_x4", "slti_neg_x5",
    "sltiu_max_x6", "srai_x7", "add_fwd_x8", "sub_x9", "sra_x10",
    "srl_x11", "sll_x12", "slt_neg_x13", "sltu_neg_x14", "xor_x15",
    "or_fwd_x16", "and_x17", "auipc_x18", "add_x0_read_x19", "jal_link_x22"
  };

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [19:0] imm,
                                         input logic [4:0] rd);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic build_program();
    prog[0]  = u_type(7'b0110111, 20'h80000, 5'd1);          // lui x1, 0x80000
    prog[1]  = i_type(12'hffd, 5'd0, 3'b000, 5'd2);          // addi x2, x0, -3
    prog[2]  = i_type(12'h004, 5'd0, 3'b000, 5'd3);          // addi x3, x0, 4
    prog[3]  = i_type(12'hff0, 5'd2, 3'b100, 5'd4);          // xori x4, x2, -16
    prog[4]  = i_type(12'hffe, 5'd2, 3'b010, 5'd5);          // slti x5, x2, -2
    prog[5]  = i_type(12'hfff, 5'd3, 3'b011, 5'd6);          // sltiu x6, x3, -1
    prog[6]  = i_type(12'h404, 5'd1, 3'b101, 5'd7);          // srai x7, x1, 4
    prog[7]  = r_type(7'h00, 5'd3, 5'd7, 3'b000, 5'd8);      // add x8, x7, x3
    prog[8]  = r_type(7'h20, 5'd2, 5'd3, 3'b000, 5'd9);      // sub x9, x3, x2
    prog[9]  = r_type(7'h20, 5'd3, 5'd1, 3'b101, 5'd10);     // sra x10, x1, x3
    prog[10] = r_type(7'h00, 5'd3, 5'd1, 3'b101, 5'd11);     // srl x11, x1, x3
    prog[11] = r_type(7'h00, 5'd3, 5'd2, 3'b001, 5'd12);     // sll x12, x2, x3
    prog[12] = r_type(7'h00, 5'd3, 5'd2, 3'b010, 5'd13);     // slt x13, x2, x3
    prog[13] = r_type(7'h00, 5'd3, 5'd2, 3'b011, 5'd14);     // sltu x14, x2, x3
    prog[14] = r_type(7'h00, 5'd2, 5'd9, 3'b100, 5'd15);     // xor x15, x9, x2
    prog[15] = r_type(7'h00, 5'd3, 5'd15, 3'b110, 5'd16);    // or x16, x15, x3
    prog[16] = r_type(7'h00, 5'd9, 5'd16, 3'b111, 5'd17);    // and x17, x16, x9
    prog[17] = u_type(7'b0010111, 20'h00001, 5'd18);         // auipc x18, 0x1
    prog[18] = r_type(7'h00, 5'd3, 5'd3, 3'b000, 5'd0);      // add x0, x3, x3
    prog[19] = r_type(7'h00, 5'd3, 5'd0, 3'b000, 5'd19);     // add x19, x0, x3
    prog[20] = b_type(13'd12, 5'd2, 5'd19, 3'b000);          // beq x19, x2 not taken
    prog[21] = b_type(13'd8, 5'd3, 5'd19, 3'b001);           // bne x19, x3 not taken
    prog[22] = b_type(13'd12, 5'd2, 5'd19, 3'b001);          // bne taken to 25
    prog[23] = i_type(12'h001, 5'd0, 3'b000, 5'd20);         // squashed
    prog[24] = i_type(12'h002, 5'd0, 3'b000, 5'd21);         // squashed
    prog[25] = b_type(13'd12, 5'd19, 5'd3, 3'b000);          // beq taken to 28
    prog[26] = i_type(12'h003, 5'd0, 3'b000, 5'd20);
    prog[27] = i_type(12'h004, 5'd0, 3'b000, 5'd21);
    prog[28] = j_type(21'd12, 5'd22);                        // jal x22 to 31
    prog[29] = i_type(12'h005, 5'd0, 3'b000, 5'd20);
    prog[30] = i_type(12'h006, 5'd0, 3'b000, 5'd21);
    prog[31] = j_type(21'd0, 5'd0);                          // park on jal x0 to itself
  endtask

  riscv_clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(RESET_CYCLES)) u_riscv_clk_gen (
    .o_clk    (clk),
    .o_arst_n (arst_n)
  );

  riscv_core riscv_core_inst (
    .i_riscv_core_clk (clk),
    .i_arst_n         (arst_n),
    .i_inst           (inst),
    .o_pc             (pc),
    .o_wb_en          (wb_en),
    .o_wb_rd          (wb_rd),
    .o_wb_data        (wb_data)
  );

  riscv_monitor u_riscv_monitor (
    .i_clk      (clk),
    .i_arst_n   (arst_n),
    .i_wb_en    (wb_en),
    .i_wb_rd    (wb_rd),
    .i_wb_data  (wb_data),
    .o_pass_cnt (pass_cnt),
    .o_fail_cnt (fail_cnt),
    .o_all_seen (all_seen)
  );

  bind riscv_core riscv_core_chk u_riscv_core_chk (
    .i_clk    (i_riscv_core_clk),
    .i_arst_n (i_arst_n),
    .i_wb_en  (o_wb_en),
    .i_wb_rd  (o_wb_rd),
    .i_pc     (o_pc)
  );

  // instruction memory read at the current pc
  always @(negedge clk) begin
    inst <= imem[pc[7:2]];
  end

  initial begin
    timed_out = 1'b0;
    cycles    = 0;
    build_program();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = i_type(12'(i), 5'd0, 3'b000, 5'd0);  // addi x0, x0, index
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      imem[i] = prog[i];
    end
    for (int i = 0; i < EXP_LEN; i++) begin
      u_riscv_monitor.add_expect(exp_name[i], exp_rd[i], exp_data[i]);
    end

    while (!all_seen && (cycles < CYCLE_LIMIT)) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    if (!all_seen) begin
      timed_out = 1'b1;
      $display("timeout after %0d cycles, not all %0d expected register writes retired",
               cycles, EXP_LEN);
    end else begin
      repeat (DRAIN_CYCLES) @(posedge clk);
    end

    chk_fails = riscv_core_inst.u_riscv_core_chk.fail_cnt;
    if (chk_fails != 0) begin
      $display("the bound checker saw %0d assertion failures", chk_fails);
    end
    $display("register writes: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (!timed_out && (fail_cnt == 0) && (pass_cnt == EXP_LEN) && (chk_fails == 0)) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
